// File: dcache_pkg.sv
// data cache shared definitions
// geometry, vector types, bus structs and the controller state encoding
// for a 4-way set-associative write-back cache
`default_nettype none

package dcache_pkg;

    //--------------------------------------------------
    // geometry
    //--------------------------------------------------
    localparam int way_cnt     = 4;
    localparam int set_cnt     = 16;
    localparam int index_bits  = 4;    // log2(set_cnt)
    localparam int offset_bits = 4;    // 16-byte line
    localparam int tag_bits    = 24;   // 32 - index - offset

    //--------------------------------------------------
    // plain vector types
    //--------------------------------------------------
    typedef logic [31:0]          addr_t;     // byte address
    typedef logic [31:0]          word_t;
    typedef logic [127:0]         line_t;     // four words
    typedef logic [tag_bits-1:0]  tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [1:0]           way_idx_t;
    typedef logic [3:0]           byte_en_t;  // one bit per byte lane

    //--------------------------------------------------
    // packed structs
    //--------------------------------------------------
    typedef struct packed {
        tag_t  tag;
        line_t line;
    } way_entry_t;                            // data ram word, 152 bits

    typedef struct packed {
        logic [way_cnt-1:0] valid;
        logic [way_cnt-1:0] dirty;
        logic [2:0]         plru;             // [0] root, [1] ways 0-1, [2] ways 2-3
    } set_ctrl_t;                             // control ram word, 11 bits

    typedef struct packed {
        addr_t    address;
        word_t    data;
        byte_en_t byte_en;
    } wr_req_t;                               // cpu write, 68 bits

    typedef struct packed {
        addr_t address;
        line_t line;
    } mem_line_t;                             // write-back payload, 160 bits

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_read_check,
        st_write_check,
        st_write_back,
        st_read_line
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: dcache_data_ram.sv
// one way of cache storage
// holds a tag and a 16-byte line per set with a registered read port
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       read_do,
    input  logic       write_do,
    input  index_t     index,
    input  way_entry_t data,
    output way_entry_t q
);

    way_entry_t mem [set_cnt];    // tag and line per set

    //--------------------------------------------------
    // write at the edge
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (write_do) begin
            mem[index] <= data;
        end
    end

    // q only moves on a read, so it stays put while the controller works the line
    always_ff @(posedge clk) begin
        if (read_do) begin
            q <= mem[index];
        end
    end

    //--------------------------------------------------
    // checks
    //--------------------------------------------------
    // controller reads only in idle and writes only after lookup
    a_no_rd_wr_same_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read_do && write_do)
    );

endmodule

`default_nettype wire

// File: dcache_control_ram.sv
// per-set control words for the data cache
// valid, dirty and tree pseudo-LRU bits held in flops and
// cleared together by reset, with a registered read
`timescale 1ns/1ps
`default_nettype none

module dcache_control_ram import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      read_do,
    input  logic      write_do,
    input  index_t    index,
    input  set_ctrl_t data,
    output set_ctrl_t q
);

    set_ctrl_t words [set_cnt];

    //--------------------------------------------------
    // storage
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < set_cnt; s++) begin
                words[s] <= '0;          // all ways invalid and clean
            end
        end else if (write_do) begin
            words[index] <= data;
        end
    end

    //--------------------------------------------------
    // read port
    //--------------------------------------------------
    // held between reads so the matcher sees a stable word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (read_do) begin
            q <= words[index];
        end
    end

    // a write to the set just read must not race its own read
    a_no_rd_wr_same_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read_do && write_do)
    );

endmodule

`default_nettype wire

// File: dcache_matched.sv
// tag compare and replacement logic
// finds the hit way, picks a victim by invalid way or tree pLRU,
// and builds the next control word for each kind of update
`timescale 1ns/1ps
`default_nettype none

module dcache_matched import dcache_pkg::*; (
    input  tag_t       tag,
    input  set_ctrl_t  ctrl,
    input  way_entry_t entry_0,
    input  way_entry_t entry_1,
    input  way_entry_t entry_2,
    input  way_entry_t entry_3,
    output logic       hit,
    output way_idx_t   hit_way,
    output line_t      hit_line,
    output way_idx_t   victim_way,
    output way_entry_t victim_entry,
    output logic       writeback_needed,
    output set_ctrl_t  ctrl_after_hit,
    output set_ctrl_t  ctrl_after_fill,
    output set_ctrl_t  ctrl_after_write_hit,
    output set_ctrl_t  ctrl_after_write_new
);

    way_entry_t         entries [way_cnt];
    logic [way_cnt-1:0] match;

    // point every tree bit on the way's path away from it
    function automatic logic [2:0] touch(input logic [2:0] plru, input way_idx_t way);
        logic [2:0] p;
        p    = plru;
        p[0] = ~way[1];                  // root points at the other half
        if (way[1]) p[2] = ~way[0];      // leaf for ways 2-3
        else        p[1] = ~way[0];      // leaf for ways 0-1
        return p;
    endfunction

    //--------------------------------------------------
    // tag match
    //--------------------------------------------------
    always_comb begin
        entries = '{entry_0, entry_1, entry_2, entry_3};
        hit_way = '0;
        for (int w = 0; w < way_cnt; w++) begin
            match[w] = ctrl.valid[w] && (entries[w].tag == tag);
            if (match[w]) hit_way = way_idx_t'(w);
        end
        hit      = |match;
        hit_line = entries[hit_way].line;
    end

    //--------------------------------------------------
    // victim choice
    //--------------------------------------------------
    always_comb begin
        if (&ctrl.valid) begin
            // set full, follow the tree
            victim_way = ctrl.plru[0] ? {1'b1, ctrl.plru[2]} : {1'b0, ctrl.plru[1]};
        end else begin
            victim_way = '0;
            for (int w = way_cnt - 1; w >= 0; w--) begin
                if (!ctrl.valid[w]) victim_way = way_idx_t'(w);   // lowest invalid wins
            end
        end
        victim_entry     = entries[victim_way];
        writeback_needed = ctrl.valid[victim_way] && ctrl.dirty[victim_way];
    end

    //--------------------------------------------------
    // next control words
    //--------------------------------------------------
    always_comb begin
        ctrl_after_hit      = ctrl;
        ctrl_after_hit.plru = touch(ctrl.plru, hit_way);

        ctrl_after_write_hit                 = ctrl_after_hit;
        ctrl_after_write_hit.dirty[hit_way]  = 1'b1;

        ctrl_after_fill                      = ctrl;
        ctrl_after_fill.valid[victim_way]    = 1'b1;
        ctrl_after_fill.dirty[victim_way]    = 1'b0;   // fresh copy of memory
        ctrl_after_fill.plru                 = touch(ctrl.plru, victim_way);

        ctrl_after_write_new                   = ctrl_after_fill;
        ctrl_after_write_new.dirty[victim_way] = 1'b1;
    end

    // duplicate tags in one set would mean a broken fill path
    always_comb begin
        if (!$isunknown(match)) begin
            a_onehot_match : assert ($onehot0(match));
        end
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
// data cache controller
// accepts cpu reads and posted writes, runs the lookup, sequences
// victim write-back and line fill, merges write bytes into lines
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    // cpu side
    input  logic             rd_do,
    input  addr_t            rd_address,
    output logic             rd_done,
    output word_t            rd_data,
    input  logic             wr_do,
    input  wr_req_t          wr_req,
    output logic             wr_done,
    // memory side
    output logic             readline_do,
    output addr_t            readline_address,
    input  logic             readline_done,
    input  line_t            readline_line,
    output logic             writeline_do,
    output mem_line_t        writeline,
    input  logic             writeline_done,
    output logic             busy,
    // ram strobes
    output logic             ram_read_do,
    output index_t           ram_index,
    output logic             ctrl_write_do,
    output set_ctrl_t        ctrl_wdata,
    output logic [way_cnt-1:0] way_write_do,
    output way_entry_t       way_wdata,
    // matcher
    output tag_t             lookup_tag,
    input  logic             hit,
    input  way_idx_t         hit_way,
    input  line_t            hit_line,
    input  way_idx_t         victim_way,
    input  way_entry_t       victim_entry,
    input  logic             writeback_needed,
    input  set_ctrl_t        ctrl_after_hit,
    input  set_ctrl_t        ctrl_after_fill,
    input  set_ctrl_t        ctrl_after_write_hit,
    input  set_ctrl_t        ctrl_after_write_new
);

    ctrl_state_t state, state_nxt;
    wr_req_t     saved;           // request being worked, data unused on reads
    logic        is_write;
    index_t      saved_index;
    logic [offset_bits-3:0] word_sel;
    line_t       base_line;
    line_t       merged_line;

    assign saved_index = saved.address[offset_bits +: index_bits];
    assign lookup_tag  = saved.address[offset_bits + index_bits +: tag_bits];
    assign word_sel    = saved.address[offset_bits-1:2];
    assign busy        = (state != st_idle);

    //--------------------------------------------------
    // request capture
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            is_write <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == st_idle) is_write <= wr_do;   // write beats read
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            if (wr_do)      saved <= wr_req;
            else if (rd_do) saved <= '{address: rd_address, data: '0, byte_en: '0};
        end
    end

    // byte merge and word select, on the hit line or the incoming fill
    always_comb begin
        base_line   = (state == st_read_line) ? readline_line : hit_line;
        merged_line = base_line;
        for (int b = 0; b < 4; b++) begin
            if (saved.byte_en[b]) begin
                merged_line[int'(word_sel) * 32 + b * 8 +: 8] = saved.data[b * 8 +: 8];
            end
        end
        rd_data = base_line[int'(word_sel) * 32 +: 32];
    end

    //--------------------------------------------------
    // memory requests, held until done
    //--------------------------------------------------
    assign readline_do      = (state == st_read_line);
    assign readline_address = {saved.address[31:offset_bits], {offset_bits{1'b0}}};
    assign writeline_do     = (state == st_write_back);
    assign writeline.address = {victim_entry.tag, saved_index, {offset_bits{1'b0}}};
    assign writeline.line    = victim_entry.line;   // ram q is frozen while busy

    assign wr_done = wr_do && (state == st_idle);   // posted

    //--------------------------------------------------
    // FSM
    //--------------------------------------------------
    always_comb begin
        state_nxt     = state;
        ram_read_do   = 1'b0;
        ram_index     = saved_index;
        ctrl_write_do = 1'b0;
        ctrl_wdata    = ctrl_after_hit;
        way_write_do  = '0;
        way_wdata     = '{tag: lookup_tag, line: merged_line};
        rd_done       = 1'b0;
        case (state)
            st_idle: begin
                ram_index = wr_do ? wr_req.address[offset_bits +: index_bits]
                                  : rd_address[offset_bits +: index_bits];
                if (wr_do || rd_do) begin
                    ram_read_do = 1'b1;                 // fetch the whole set
                    state_nxt   = wr_do ? st_write_check : st_read_check;
                end
            end
            st_read_check, st_write_check: begin
                if (hit) begin
                    ctrl_write_do = 1'b1;
                    if (is_write) begin
                        ctrl_wdata            = ctrl_after_write_hit;
                        way_write_do[hit_way] = 1'b1;
                    end else begin
                        rd_done = 1'b1;                 // one cycle after accept
                    end
                    state_nxt = st_idle;
                end else begin
                    state_nxt = writeback_needed ? st_write_back : st_read_line;
                end
            end
            st_write_back: begin
                if (writeline_done) state_nxt = st_read_line;
            end
            st_read_line: begin
                if (readline_done) begin
                    ctrl_write_do            = 1'b1;
                    ctrl_wdata               = is_write ? ctrl_after_write_new : ctrl_after_fill;
                    way_write_do[victim_way] = 1'b1;
                    rd_done                  = !is_write;
                    state_nxt                = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    //--------------------------------------------------
    // checks
    //--------------------------------------------------
    a_one_mem_req : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(readline_do && writeline_do)
    );

    // a posted write is only taken from idle and always goes to lookup
    a_wr_done_idle : assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_done |-> (state == st_idle) ##1 (state == st_write_check)
    );

endmodule

`default_nettype wire

// File: dcache.sv
// 4-way set-associative write-back data cache, top level
// connects the controller, matcher, control ram and four way rams
`timescale 1ns/1ps
`default_nettype none

module dcache import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // cpu read
    input  logic      rd_do,
    input  addr_t     rd_address,
    output logic      rd_done,
    output word_t     rd_data,
    // cpu write, posted
    input  logic      wr_do,
    input  wr_req_t   wr_req,
    output logic      wr_done,
    // line fill
    output logic      readline_do,
    output addr_t     readline_address,
    input  logic      readline_done,
    input  line_t     readline_line,
    // line write-back
    output logic      writeline_do,
    output mem_line_t writeline,
    input  logic      writeline_done,
    output logic      busy
);

    //--------------------------------------------------
    // internal buses
    //--------------------------------------------------
    logic               ram_read_do;
    index_t             ram_index;
    logic               ctrl_write_do;
    set_ctrl_t          ctrl_wdata, ctrl_q;
    logic [way_cnt-1:0] way_write_do;
    way_entry_t         way_wdata;
    way_entry_t         way_q_0, way_q_1, way_q_2, way_q_3;

    tag_t               lookup_tag;
    logic               hit, writeback_needed;
    way_idx_t           hit_way, victim_way;
    line_t              hit_line;
    way_entry_t         victim_entry;
    set_ctrl_t          ctrl_after_hit, ctrl_after_fill;
    set_ctrl_t          ctrl_after_write_hit, ctrl_after_write_new;

    dcache_ctrl i_ctrl (.*);

    dcache_matched i_matched (
        .tag     (lookup_tag),
        .ctrl    (ctrl_q),
        .entry_0 (way_q_0),
        .entry_1 (way_q_1),
        .entry_2 (way_q_2),
        .entry_3 (way_q_3),
        .*
    );

    dcache_control_ram i_control_ram (
        .clk, .rst_n,
        .read_do (ram_read_do), .write_do (ctrl_write_do),
        .index   (ram_index),   .data     (ctrl_wdata),
        .q       (ctrl_q)
    );

    //--------------------------------------------------
    // way storage, one write strobe each
    //--------------------------------------------------
    dcache_data_ram i_way0 (.clk, .rst_n, .read_do (ram_read_do), .write_do (way_write_do[0]),
                            .index (ram_index), .data (way_wdata), .q (way_q_0));
    dcache_data_ram i_way1 (.clk, .rst_n, .read_do (ram_read_do), .write_do (way_write_do[1]),
                            .index (ram_index), .data (way_wdata), .q (way_q_1));
    dcache_data_ram i_way2 (.clk, .rst_n, .read_do (ram_read_do), .write_do (way_write_do[2]),
                            .index (ram_index), .data (way_wdata), .q (way_q_2));
    dcache_data_ram i_way3 (.clk, .rst_n, .read_do (ram_read_do), .write_do (way_write_do[3]),
                            .index (ram_index), .data (way_wdata), .q (way_q_3));

endmodule

`default_nettype wire

// File: dcache_checker.sv
// scoreboard for the data cache testbench
// keeps a shadow word memory, checks read data, fills and write-backs,
// and reports one line per test
`timescale 1ns/1ps
`default_nettype none

module dcache_checker import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         rd_done,
    input  word_t        rd_data,
    input  logic         wr_done,
    input  wr_req_t      wr_req,
    input  logic         readline_do,
    input  addr_t        readline_address,
    input  logic         readline_done,
    input  logic         writeline_do,
    input  mem_line_t    writeline,
    input  logic         writeline_done,
    input  logic         busy,
    input  logic [159:0] test_name,
    input  logic         test_write,
    input  addr_t        test_addr,
    input  int           exp_fill,
    input  int           exp_wb,
    input  logic         test_end,
    output int           error_count,
    output int           pass_count,
    output int           fail_count
);

    word_t shadow [addr_t];     // cpu view of memory, word addressed
    int    fill_seen;
    int    wb_seen;
    int    rd_seen;
    int    wr_seen;
    int    test_errors;
    int    test_num;
    logic  reset_checked;

    function automatic word_t init_word(addr_t a);
        return (a ^ 32'h5a5a_c3c3) * 32'h9e37_79b1 + {a[15:0], a[31:16]};
    endfunction

    function automatic word_t shadow_word(addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return init_word(wa);
    endfunction

    function automatic line_t shadow_line(addr_t a);
        line_t l;
        for (int w = 0; w < 4; w++) l[w * 32 +: 32] = shadow_word({a[31:4], 4'h0} + addr_t'(w * 4));
        return l;
    endfunction

    //--------------------------------------------------
    // everything sampled mid-cycle
    //--------------------------------------------------
    always @(negedge clk) begin
        word_t w;
        line_t exp_line;
        if (!rst_n) begin
            error_count = 0;
            pass_count  = 0;
            fail_count  = 0;
            fill_seen   = 0;
            wb_seen     = 0;
            rd_seen     = 0;
            wr_seen     = 0;
            test_errors = 0;
            test_num    = 0;
            reset_checked = 1'b0;
        end else begin
            if (!reset_checked) begin
                if (busy || rd_done || wr_done || readline_do || writeline_do) begin
                    $display("outputs not idle after reset: busy %b rd_done %b wr_done %b rl %b wl %b",
                             busy, rd_done, wr_done, readline_do, writeline_do);
                    error_count++;
                end
                reset_checked = 1'b1;
            end
            if (wr_done) begin              // posted write, merge enabled bytes
                w = shadow_word(wr_req.address);
                for (int b = 0; b < 4; b++) begin
                    if (wr_req.byte_en[b]) w[b * 8 +: 8] = wr_req.data[b * 8 +: 8];
                end
                shadow[{wr_req.address[31:2], 2'b00}] = w;
                wr_seen++;
            end
            if (rd_done) begin
                rd_seen++;
                if (rd_data !== shadow_word(test_addr)) begin
                    $display("ERROR %0s: read data expected %h actual %h",
                             test_name, shadow_word(test_addr), rd_data);
                    test_errors++;
                end
            end
            if (readline_do && readline_done) begin
                fill_seen++;
                if (readline_address !== {test_addr[31:4], 4'h0}) begin
                    $display("ERROR %0s: fill address expected %h actual %h",
                             test_name, {test_addr[31:4], 4'h0}, readline_address);
                    test_errors++;
                end
            end
            if (writeline_do && writeline_done) begin
                wb_seen++;
                exp_line = shadow_line(writeline.address);
                if (fill_seen != 0) begin
                    $display("%0s: write-back came after the line fill", test_name);
                    test_errors++;
                end
                if (writeline.address[offset_bits +: index_bits] !==
                        test_addr[offset_bits +: index_bits] || writeline.address[3:0] !== 4'h0) begin
                    $display("%0s: write-back address %h is not a line of the request's set",
                             test_name, writeline.address);
                    test_errors++;
                end
                if (writeline.line !== exp_line) begin
                    $display("ERROR %0s: write-back line expected %h actual %h",
                             test_name, exp_line, writeline.line);
                    test_errors++;
                end
            end
            if (test_end) begin
                test_num++;
                if (exp_fill >= 0 && fill_seen != exp_fill) begin
                    $display("ERROR %0s: readline count expected %0d actual %0d",
                             test_name, exp_fill, fill_seen);
                    test_errors++;
                end
                if (exp_wb >= 0 && wb_seen != exp_wb) begin
                    $display("ERROR %0s: writeline count expected %0d actual %0d",
                             test_name, exp_wb, wb_seen);
                    test_errors++;
                end
                if (test_write ? (wr_seen != 1) : (rd_seen != 1)) begin
                    $display("%0s: request answered %0d times instead of once",
                             test_name, test_write ? wr_seen : rd_seen);
                    test_errors++;
                end
                if (test_errors == 0) begin
                    pass_count++;
                    $display("test %0d %0s: ok, fills %0d, write-backs %0d",
                             test_num, test_name, fill_seen, wb_seen);
                end else begin
                    fail_count++;
                    $display("test %0d %0s: FAILED, %0d errors", test_num, test_name, test_errors);
                end
                error_count += test_errors;
                fill_seen   = 0;            // fresh counts for the next test
                wb_seen     = 0;
                rd_seen     = 0;
                wr_seen     = 0;
                test_errors = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_dcache.sv
// testbench for the 4-way write-back data cache
// clock, reset, line memory model, stimulus table, LCG and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    typedef struct {
        logic [159:0] name;
        logic         is_write;   // 1 write, 0 read
        addr_t        addr;
        word_t        data;
        byte_en_t     be;
        int           exp_fill;   // readline requests expected, -1 any
        int           exp_wb;     // writeline requests expected, -1 any
    } test_t;

    logic      clk;
    logic      rst_n;
    logic      rd_do;
    addr_t     rd_address;
    logic      rd_done;
    word_t     rd_data;
    logic      wr_do;
    wr_req_t   wr_req;
    logic      wr_done;
    logic      readline_do;
    addr_t     readline_address;
    logic      readline_done;
    line_t     readline_line;
    logic      writeline_do;
    mem_line_t writeline;
    logic      writeline_done;
    logic      busy;

    logic [159:0] cur_name;
    logic         cur_write;
    addr_t        cur_addr;
    int           cur_fill;
    int           cur_wb;
    logic         test_end;
    int           error_count;
    int           pass_count;
    int           fail_count;

    test_t       tests [$];
    line_t       mem_lines [addr_t];    // lines written back by the cache
    int unsigned lcg_state = 95;

    dcache i_dut (.*);

    dcache_checker i_checker (
        .clk, .rst_n, .rd_done, .rd_data, .wr_done, .wr_req,
        .readline_do, .readline_address, .readline_done,
        .writeline_do, .writeline, .writeline_done, .busy,
        .test_name (cur_name), .test_write (cur_write), .test_addr (cur_addr),
        .exp_fill  (cur_fill), .exp_wb     (cur_wb),    .test_end,
        .error_count, .pass_count, .fail_count
    );

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;         // upper bits, better spread
    endfunction

    // memory contents before any write-back
    function automatic word_t init_word(addr_t a);
        return (a ^ 32'h5a5a_c3c3) * 32'h9e37_79b1 + {a[15:0], a[31:16]};
    endfunction

    function automatic line_t fetch_line(addr_t a);
        line_t l;
        if (mem_lines.exists(a)) begin
            l = mem_lines[a];
        end else begin
            for (int w = 0; w < 4; w++) l[w * 32 +: 32] = init_word(a + addr_t'(w * 4));
        end
        return l;
    endfunction

    function automatic addr_t make_addr(int unsigned tag, int unsigned set, int unsigned word);
        return {tag_t'(tag), index_t'(set), 2'(word), 2'b00};
    endfunction

    task automatic add_test(input logic [159:0] name, input logic is_write, input addr_t addr,
                            input word_t data, input byte_en_t be, input int exp_fill,
                            input int exp_wb);
        test_t t;
        t = '{name, is_write, addr, data, be, exp_fill, exp_wb};
        tests.push_back(t);
    endtask

    //--------------------------------------------------
    // stimulus table
    //--------------------------------------------------
    task automatic build_table();
        int unsigned r;
        word_t       d;
        int unsigned sets [3];
        sets = '{3, 8, 12};
        // cold miss, then hits in the same line
        add_test("cold_read",    1'b0, make_addr('h100, 3, 1), '0, '0, 1, 0);
        add_test("reread_word",  1'b0, make_addr('h100, 3, 1), '0, '0, 0, 0);
        add_test("reread_line",  1'b0, make_addr('h100, 3, 2), '0, '0, 0, 0);
        // partial byte enables, resident and new line
        add_test("wr_resident",  1'b1, make_addr('h100, 3, 1), 32'hdead_beef, 4'b0101, 0, 0);
        add_test("rd_resident",  1'b0, make_addr('h100, 3, 1), '0, '0, 0, 0);
        add_test("wr_new_line",  1'b1, make_addr('h200, 6, 3), 32'h1234_5678, 4'b1100, 1, 0);
        add_test("rd_new_line",  1'b0, make_addr('h200, 6, 3), '0, '0, 0, 0);
        // fill ways 0..3 of set 8, fifth line takes way 0
        for (int t = 1; t <= 4; t++) begin
            add_test("plru_fill",  1'b0, make_addr('h400 + t, 8, 0), '0, '0, 1, 0);
        end
        add_test("plru_fifth",   1'b0, make_addr('h405, 8, 0), '0, '0, 1, 0);
        for (int t = 2; t <= 4; t++) begin
            add_test("plru_hit",   1'b0, make_addr('h400 + t, 8, 0), '0, '0, 0, 0);
        end
        add_test("plru_evicted", 1'b0, make_addr('h401, 8, 0), '0, '0, 1, 0);
        // dirty line in way 0 of set 12 pushed out by conflicting reads
        add_test("dirty_write",  1'b1, make_addr('h501, 12, 2), 32'hcafe_f00d, 4'b1111, 1, 0);
        for (int t = 2; t <= 4; t++) begin
            add_test("dirty_fill", 1'b0, make_addr('h500 + t, 12, 0), '0, '0, 1, 0);
        end
        add_test("dirty_evict",  1'b0, make_addr('h505, 12, 0), '0, '0, 1, 1);
        add_test("dirty_reread", 1'b0, make_addr('h501, 12, 2), '0, '0, 1, 0);
        // random mix, 8 tags x 2 words x 3 sets
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            d = next_rand() << 16;
            d = d ^ next_rand();
            add_test("random", (r % 3) == 0,
                     make_addr('h300 + (r >> 4) % 8, sets[(r >> 8) % 3], ((r >> 12) % 2) * 3),
                     d, byte_en_t'(next_rand()), -1, -1);
        end
    endtask

    task automatic run_test(input test_t t);
        @(posedge clk);
        #1;
        cur_name  = t.name;
        cur_write = t.is_write;
        cur_addr  = t.addr;
        cur_fill  = t.exp_fill;
        cur_wb    = t.exp_wb;
        if (t.is_write) begin
            wr_req = '{address: t.addr, data: t.data, byte_en: t.be};
            wr_do  = 1'b1;
            @(posedge clk);            // taken in idle
            #1;
            wr_do = 1'b0;
            do @(negedge clk); while (busy);
        end else begin
            rd_address = t.addr;
            rd_do      = 1'b1;
            do @(negedge clk); while (!rd_done);
        end
        @(posedge clk);
        #1;
        rd_do    = 1'b0;
        test_end = 1'b1;               // checker closes the test
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    //--------------------------------------------------
    // clock, memory model, watchdog
    //--------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : memory_model
        int unsigned wait_cycles;
        readline_done  = 1'b0;
        readline_line  = '0;
        writeline_done = 1'b0;
        forever begin
            @(negedge clk);
            if (readline_do || writeline_do) begin
                wait_cycles = 1 + next_rand() % 4;
                repeat (wait_cycles) @(posedge clk);
                #1;
                if (readline_do) begin
                    readline_line = fetch_line(readline_address);
                    readline_done = 1'b1;
                end else begin
                    mem_lines[writeline.address] = writeline.line;
                    writeline_done = 1'b1;
                end
                @(posedge clk);
                #1;
                readline_done  = 1'b0;
                writeline_done = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (tests.size() * 40) @(posedge clk);
        $display("watchdog expired, the cache stopped answering during test %0s", cur_name);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        rst_n      = 1'b0;
        rd_do      = 1'b0;
        rd_address = '0;
        wr_do      = 1'b0;
        wr_req     = '0;
        cur_name   = '0;
        cur_write  = 1'b0;
        cur_addr   = '0;
        cur_fill   = -1;
        cur_wb     = -1;
        test_end   = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (tests[i]) run_test(tests[i]);
        @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests.size(), pass_count, fail_count, error_count);
        if (error_count == 0 && pass_count == tests.size()) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
dcache_pkg.sv
dcache_data_ram.sv
dcache_control_ram.sv
dcache_matched.sv
dcache_ctrl.sv
dcache.sv
dcache_checker.sv
tb_dcache.sv

// File: run.sh
#!/bin/bash
# build and run the data cache testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache -f sources.f -o tb_dcache

./obj_dir/tb_dcache | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "testbench reported a failure, see sim.log"
    exit 1
fi
exit 0
